// File: dataCache.f
design/dataCachePkg.sv
design/storeMerge.sv
design/cacheArray.sv
design/cacheControl.sv
design/dataCache.sv
bench/dataCacheProps.sv
bench/dataCacheTb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the data cache testbench with Verilator

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
logFile=sim.log

if ! verilator --binary --timing --assert -j 0 --top-module dataCacheTb \
        -Mdir "$buildDir" -f dataCache.f; then
    echo "Verilator build failed"
    exit 1
fi

# Keep going past single assertion errors so the bench reaches its verdict
if ! "./$buildDir/VdataCacheTb" +verilator+error+limit+1000 > "$logFile" 2>&1; then
    cat "$logFile"
    echo "Simulation exited with an error status"
    exit 1
fi
cat "$logFile"

if ! grep -qF "*** TEST PASSED ***" "$logFile"; then
    exit 1
fi
exit 0

// File: bench/dataCacheTb.sv
`timescale 1ns/10ps

module dataCacheTb import dataCachePkg::*; ();

    localparam int memLines      = 64;
    localparam int timeoutCycles = 40;

    logic                 Clk, arstN, En, RW, Stall;
    logic [wordWidth-1:0] Address, WData, RData, lineWriteAddr, lineFillAddr;
    logic                 lineWriteEnable, lineWriteDone, lineFillEnable, lineFillDone;
    logic [lineWidth-1:0] lineWriteData, lineFillData;

    // Memory image, plus the view the processor should see
    logic [lineWidth-1:0] memData [memLines];
    logic [lineWidth-1:0] refData [memLines];

    // Expected read word, also watched by the bound properties
    logic [wordWidth-1:0] expRData;

    // Memory traffic log
    int                   writeCount, fillCount;
    logic [wordWidth-1:0] lastWriteAddr, lastFillAddr;
    logic [lineWidth-1:0] lastWriteData;

    logic [31:0] lfsr;
    int          errorCount, testCount, failedTests;
    logic        timedOut;

    // lineCount stays at its default of 32
    dataCache i_dataCache (.*);

    bind dataCache dataCacheProps i_props (.*);

    initial begin
        Clk = 1'b0;
        forever begin
            #4 Clk = ~Clk;
        end
    end

    ////////////////////
    // Helpers
    ////////////////////

    // Galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic randomBits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr  = lfsrNext(lfsr);
            value = {value[30:0], lfsr[0]};
        end
    endtask

    task automatic checkWord(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
            errorCount++;
        end
    endtask

    // Request held from a falling edge until Stall drops
    task automatic access(input string name, input logic write, input logic [31:0] addr,
                          input logic [31:0] data, output int stalls);
        logic [wordWidth-1:0] expWord;
        expWord = refData[addr[10:5]][addr[4:2]*wordWidth +: wordWidth];
        stalls  = 0;
        if (!timedOut) begin
            En       = 1'b1;
            RW       = write;
            Address  = addr;
            WData    = data;
            expRData = expWord;
            // Sample mid cycle, away from both edges
            #1;
            while (Stall && stalls < timeoutCycles) begin
                @(negedge Clk);
                #1;
                stalls++;
            end
            if (Stall) begin
                $display("%s: request to %h still stalled after %0d cycles", name, addr, stalls);
                errorCount++;
                timedOut = 1'b1;
            end else if (!write) begin
                checkWord({name, " read data"}, expWord, RData);
            end else begin
                refData[addr[10:5]][addr[4:2]*wordWidth +: wordWidth] = data;
            end
            // Past the retiring edge
            @(negedge Clk);
            En = 1'b0;
        end
    endtask

    task automatic endTest(input string name, input int errorsBefore);
        testCount++;
        if (errorCount == errorsBefore) begin
            $display("%s: ok", name);
        end else begin
            failedTests++;
            $display("%s: %0d errors", name, errorCount - errorsBefore);
        end
    endtask

    ////////////////////
    // Memory model
    ////////////////////

    initial begin : memoryModel
        logic [31:0] delay;
        lineWriteDone = 1'b0;
        lineFillDone  = 1'b0;
        lineFillData  = '0;
        writeCount    = 0;
        fillCount     = 0;
        forever begin
            @(negedge Clk);
            lineWriteDone = 1'b0;
            lineFillDone  = 1'b0;
            if (lineWriteEnable || lineFillEnable) begin
                // Enable high for 2 to 5 cycles, done cycle included
                randomBits(2, delay);
                repeat (delay + 1) @(negedge Clk);
                if (lineWriteEnable) begin
                    memData[lineWriteAddr[10:5]] = lineWriteData;
                    lastWriteAddr = lineWriteAddr;
                    lastWriteData = lineWriteData;
                    writeCount++;
                    lineWriteDone = 1'b1;
                end else begin
                    lineFillData = memData[lineFillAddr[10:5]];
                    lastFillAddr = lineFillAddr;
                    fillCount++;
                    lineFillDone = 1'b1;
                end
            end
        end
    end

    ////////////////////
    // Stimulus
    ////////////////////

    initial begin : stimulus
        int          stalls;
        int          startErrors;
        int          fills;
        int          writes;
        logic [31:0] value;
        arstN       = 1'b0;
        En          = 1'b0;
        RW          = 1'b0;
        Address     = '0;
        WData       = '0;
        expRData    = '0;
        errorCount  = 0;
        testCount   = 0;
        failedTests = 0;
        timedOut    = 1'b0;
        lfsr        = 32'h9d23_9708;
        for (int l = 0; l < memLines; l++) begin
            for (int b = 0; b < lineWidth; b++) begin
                randomBits(1, value);
                memData[l][b] = value[0];
            end
            refData[l] = memData[l];
        end
        repeat (4) @(negedge Clk);
        arstN = 1'b1;
        @(negedge Clk);

        // Cold read of line 0x40, then a hit in the same line
        startErrors = errorCount;
        fills       = fillCount;
        writes      = writeCount;
        access("readMissHit", 1'b0, 32'h0000_004c, '0, stalls);
        checkWord("readMissHit fill count", fills + 1, fillCount);
        checkWord("readMissHit fill address", 32'h0000_0040, lastFillAddr);
        access("readMissHit", 1'b0, 32'h0000_0044, '0, stalls);
        checkWord("readMissHit hit stalls", 0, stalls);
        checkWord("readMissHit write-backs", writes, writeCount);
        endTest("readMissHit", startErrors);

        // Store into the resident line, no traffic expected
        startErrors = errorCount;
        fills       = fillCount;
        randomBits(32, value);
        access("writeHit", 1'b1, 32'h0000_0048, value, stalls);
        checkWord("writeHit write stalls", 0, stalls);
        access("writeHit", 1'b0, 32'h0000_0048, '0, stalls);
        checkWord("writeHit read stalls", 0, stalls);
        checkWord("writeHit fill count", fills, fillCount);
        checkWord("writeHit write-backs", writes, writeCount);
        endTest("writeHit", startErrors);

        // Store miss, word 5 of line 0x180 merged at install
        startErrors = errorCount;
        fills       = fillCount;
        writes      = writeCount;
        randomBits(32, value);
        access("writeMissMerge", 1'b1, 32'h0000_0194, value, stalls);
        checkWord("writeMissMerge fill count", fills + 1, fillCount);
        checkWord("writeMissMerge fill address", 32'h0000_0180, lastFillAddr);
        checkWord("writeMissMerge write-backs", writes, writeCount);
        for (int w = 0; w < wordsPerLine; w++) begin
            access("writeMissMerge", 1'b0, 32'h0000_0180 + 4 * w, '0, stalls);
            checkWord("writeMissMerge read stalls", 0, stalls);
        end
        endTest("writeMissMerge", startErrors);

        // Second store to line 0x40, then 0x440 takes its slot
        startErrors = errorCount;
        randomBits(32, value);
        access("dirtyEviction", 1'b1, 32'h0000_005c, value, stalls);
        fills  = fillCount;
        writes = writeCount;
        access("dirtyEviction", 1'b0, 32'h0000_0440, '0, stalls);
        checkWord("dirtyEviction write-backs", writes + 1, writeCount);
        checkWord("dirtyEviction victim address", 32'h0000_0040, lastWriteAddr);
        assert (lastWriteData == refData[2]) else begin
            $display("FAILED dirtyEviction victim line: expected %h, actual %h",
                     refData[2], lastWriteData);
            errorCount++;
        end
        checkWord("dirtyEviction fill count", fills + 1, fillCount);
        checkWord("dirtyEviction fill address", 32'h0000_0440, lastFillAddr);
        // Both stores must come back from memory
        access("dirtyEviction", 1'b0, 32'h0000_0048, '0, stalls);
        access("dirtyEviction", 1'b0, 32'h0000_005c, '0, stalls);
        endTest("dirtyEviction", startErrors);

        // Line 0x3a0 only read, then replaced by 0x7a0
        startErrors = errorCount;
        access("cleanEviction", 1'b0, 32'h0000_03a0, '0, stalls);
        fills  = fillCount;
        writes = writeCount;
        access("cleanEviction", 1'b0, 32'h0000_07a4, '0, stalls);
        checkWord("cleanEviction fill count", fills + 1, fillCount);
        checkWord("cleanEviction fill address", 32'h0000_07a0, lastFillAddr);
        checkWord("cleanEviction write-backs", writes, writeCount);
        endTest("cleanEviction", startErrors);

        // Bound properties have watched every cycle so far
        startErrors = errorCount;
        checkWord("portProtocol assertion failures", 0, i_dataCache.i_props.failCount);
        endTest("portProtocol", startErrors);

        $display("%0d tests, %0d failed, %0d errors", testCount, failedTests, errorCount);
        if (errorCount == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

// File: bench/dataCacheProps.sv
`timescale 1ns/10ps

module dataCacheProps import dataCachePkg::*; (
    input logic                 Clk,
    input logic                 arstN,
    input logic                 En,
    input logic                 RW,
    input logic                 Stall,
    input logic [wordWidth-1:0] RData,
    input logic                 lineWriteEnable,
    input logic                 lineWriteDone,
    input logic [wordWidth-1:0] lineWriteAddr,
    input logic                 lineFillEnable,
    input logic                 lineFillDone,
    input logic [wordWidth-1:0] lineFillAddr
);

    // Running count of failed properties
    int failCount = 0;

    // FSM state and the bench's expected read word
    cacheState            ctlState;
    logic [wordWidth-1:0] expRData;

    assign ctlState = dataCacheTb.i_dataCache.i_cacheControl.state;
    assign expRData = dataCacheTb.expRData;

    ////////////////////
    // Port protocol
    ////////////////////

    // Quiet in reset and on release
    quietReset: assert property (@(posedge Clk)
        (!arstN || $rose(arstN)) |-> (!Stall && !lineWriteEnable && !lineFillEnable))
    else begin
        $error("Stall or a memory enable active around reset");
        failCount++;
    end

    // One memory port at a time
    oneEnable: assert property (@(posedge Clk) disable iff (!arstN)
        !(lineWriteEnable && lineFillEnable))
    else begin
        $error("write-back and fill enables high together");
        failCount++;
    end

    // Enables hold until their done pulse
    writeHeld: assert property (@(posedge Clk) disable iff (!arstN)
        (lineWriteEnable && !lineWriteDone) |=> lineWriteEnable)
    else begin
        $error("lineWriteEnable dropped before lineWriteDone");
        failCount++;
    end

    fillHeld: assert property (@(posedge Clk) disable iff (!arstN)
        (lineFillEnable && !lineFillDone) |=> lineFillEnable)
    else begin
        $error("lineFillEnable dropped before lineFillDone");
        failCount++;
    end

    // Line aligned addresses only
    writeAligned: assert property (@(posedge Clk) disable iff (!arstN)
        lineWriteEnable |-> (lineWriteAddr[offsetBits-1:0] == '0))
    else begin
        $error("write-back address with nonzero offset bits");
        failCount++;
    end

    fillAligned: assert property (@(posedge Clk) disable iff (!arstN)
        lineFillEnable |-> (lineFillAddr[offsetBits-1:0] == '0))
    else begin
        $error("fill address with nonzero offset bits");
        failCount++;
    end

    ////////////////////
    // Data and sequencing
    ////////////////////

    // Every retiring read
    readData: assert property (@(posedge Clk) disable iff (!arstN)
        (En && !RW && !Stall) |-> (RData == expRData))
    else begin
        $error("retiring read returned %h, bench expected %h", RData, expRData);
        failCount++;
    end

    // Read miss retries and hits right after its refill
    readRetry: assert property (@(posedge Clk) disable iff (!arstN)
        $past(ctlState == refill && En && !RW) |-> !Stall)
    else begin
        $error("read still stalled in the cycle after its refill");
        failCount++;
    end

    // Write miss retires the cycle after the fill done pulse
    writeRetire: assert property (@(posedge Clk) disable iff (!arstN)
        $past(lineFillDone && En && RW) |-> !Stall)
    else begin
        $error("write miss still stalled after its fill completed");
        failCount++;
    end

endmodule

// File: design/dataCache.sv
`timescale 1ns/10ps

module dataCache import dataCachePkg::*; #(
    parameter int lineCount = 32
) (
    input  logic                 Clk,
    input  logic                 arstN,
    // Processor request
    input  logic                 En,
    input  logic                 RW,
    input  logic [wordWidth-1:0] Address,
    input  logic [wordWidth-1:0] WData,
    output logic [wordWidth-1:0] RData,
    output logic                 Stall,
    // Victim write-back port
    output logic                 lineWriteEnable,
    input  logic                 lineWriteDone,
    output logic [wordWidth-1:0] lineWriteAddr,
    output logic [lineWidth-1:0] lineWriteData,
    // Line fill port
    output logic                 lineFillEnable,
    output logic [wordWidth-1:0] lineFillAddr,
    input  logic                 lineFillDone,
    input  logic [lineWidth-1:0] lineFillData
);

    ////////////////////
    // Internal wiring
    ////////////////////

    // Array status to the FSM
    logic hit;
    logic victimDirty;

    // FSM strobes
    logic wordWrite;
    logic lineInstall;
    logic mergeStore;
    logic captureStore;

    // Fill line, store word already merged in if needed
    logic [lineWidth-1:0] mergedLine;

    // Sequencing of hits, write-back, fill and refill
    cacheControl i_cacheControl (
        .Clk             (Clk),
        .arstN           (arstN),
        .En              (En),
        .RW              (RW),
        .hit             (hit),
        .victimDirty     (victimDirty),
        .lineWriteDone   (lineWriteDone),
        .lineFillDone    (lineFillDone),
        .Stall           (Stall),
        .wordWrite       (wordWrite),
        .lineInstall     (lineInstall),
        .mergeStore      (mergeStore),
        .captureStore    (captureStore),
        .lineWriteEnable (lineWriteEnable),
        .lineFillEnable  (lineFillEnable)
    );

    // Tags, state bits and line storage
    cacheArray #(
        .lineCount (lineCount)
    ) i_cacheArray (
        .Clk           (Clk),
        .arstN         (arstN),
        .Address       (Address),
        .WData         (WData),
        .wordWrite     (wordWrite),
        .lineInstall   (lineInstall),
        .mergeStore    (mergeStore),
        .mergedLine    (mergedLine),
        .RData         (RData),
        .hit           (hit),
        .victimDirty   (victimDirty),
        .lineWriteAddr (lineWriteAddr),
        .lineWriteData (lineWriteData),
        .lineFillAddr  (lineFillAddr)
    );

    // Pending store word and its merge into the fill line
    storeMerge i_storeMerge (
        .Clk          (Clk),
        .arstN        (arstN),
        .captureStore (captureStore),
        .Address      (Address),
        .WData        (WData),
        .mergeStore   (mergeStore),
        .lineFillData (lineFillData),
        .mergedLine   (mergedLine)
    );

endmodule

// File: design/cacheControl.sv
`timescale 1ns/10ps

module cacheControl import dataCachePkg::*; (
    input  logic Clk,
    input  logic arstN,
    // Processor request
    input  logic En,
    input  logic RW,
    // Array status
    input  logic hit,
    input  logic victimDirty,
    // Memory done pulses
    input  logic lineWriteDone,
    input  logic lineFillDone,
    // Processor hold
    output logic Stall,
    // Array and merge strobes
    output logic wordWrite,
    output logic lineInstall,
    output logic mergeStore,
    output logic captureStore,
    // Memory enables
    output logic lineWriteEnable,
    output logic lineFillEnable
);

    ////////////////////
    // State register
    ////////////////////

    cacheState state;
    cacheState nextState;

    // Request looked at only while idle
    logic reqMiss;
    logic reqHit;

    assign reqHit  = En && hit;
    assign reqMiss = En && !hit;

    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            state <= idle;
        end else begin
            state <= nextState;
        end
    end

    ////////////////////
    // Next state
    ////////////////////

    always_comb begin
        nextState = state;
        case (state)
            idle: begin
                // Dirty victim must leave before the fill starts
                if (reqMiss) begin
                    if (victimDirty) begin
                        nextState = writeBack;
                    end else begin
                        nextState = fill;
                    end
                end
            end
            writeBack: begin
                // Held until memory takes the line
                if (lineWriteDone) begin
                    nextState = fill;
                end
            end
            fill: begin
                // Latency set by memory, ends on the done pulse
                if (lineFillDone) begin
                    nextState = refill;
                end
            end
            refill: begin
                // Single install cycle
                nextState = idle;
            end
            default: begin
                nextState = idle;
            end
        endcase
    end

    ////////////////////
    // Outputs
    ////////////////////

    // Enables are plain state decodes
    // they fall one cycle after the done pulse
    assign lineWriteEnable = (state == writeBack);
    assign lineFillEnable  = (state == fill);

    // Write hit commits straight into the array
    assign wordWrite = (state == idle) && reqHit && RW;

    // Store word saved once, in the cycle the miss shows up
    assign captureStore = (state == idle) && reqMiss && RW;

    // Install in refill, merged only for a write miss
    // request is held stable, so RW still tells the miss type
    assign lineInstall = (state == refill);
    assign mergeStore  = (state == refill) && RW;

    always_comb begin
        case (state)
            idle: begin
                // Combinational stall on a miss
                Stall = reqMiss;
            end
            writeBack, fill: begin
                Stall = 1'b1;
            end
            refill: begin
                // Write retires at install, read retries next cycle
                Stall = !RW;
            end
            default: begin
                Stall = 1'b1;
            end
        endcase
    end

endmodule

// File: design/cacheArray.sv
`timescale 1ns/10ps

module cacheArray import dataCachePkg::*; #(
    parameter int lineCount = 32
) (
    input  logic                 Clk,
    input  logic                 arstN,
    // Request fields
    input  logic [wordWidth-1:0] Address,
    input  logic [wordWidth-1:0] WData,
    // Strobes from the FSM
    input  logic                 wordWrite,
    input  logic                 lineInstall,
    input  logic                 mergeStore,
    // Line to install
    input  logic [lineWidth-1:0] mergedLine,
    // Read side
    output logic [wordWidth-1:0] RData,
    output logic                 hit,
    output logic                 victimDirty,
    // Memory addresses and victim data
    output logic [wordWidth-1:0] lineWriteAddr,
    output logic [lineWidth-1:0] lineWriteData,
    output logic [wordWidth-1:0] lineFillAddr
);

    ////////////////////
    // Address fields
    ////////////////////

    localparam int indexBits = $clog2(lineCount);
    localparam int tagBits   = wordWidth - indexBits - offsetBits;

    logic [indexBits-1:0]   index;
    logic [tagBits-1:0]     reqTag;
    logic [wordSelBits-1:0] wordSel;

    assign index   = Address[offsetBits +: indexBits];
    assign reqTag  = Address[wordWidth-1 -: tagBits];
    assign wordSel = Address[wordSelLow +: wordSelBits];

    ////////////////////
    // Storage
    ////////////////////

    logic [tagBits-1:0]   tags  [lineCount];
    logic [lineWidth-1:0] lines [lineCount];

    // One bit per line
    logic [lineCount-1:0] valid;
    logic [lineCount-1:0] dirty;

    // Line state bits, cleared on reset
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            valid <= '0;
            dirty <= '0;
        end else if (lineInstall) begin
            valid[index] <= 1'b1;
            // Clean for a read miss, dirty for a merged store
            dirty[index] <= mergeStore;
        end else if (wordWrite) begin
            dirty[index] <= 1'b1;
        end
    end

    // Tags and data
    always_ff @(posedge Clk) begin
        if (lineInstall) begin
            tags[index]  <= reqTag;
            lines[index] <= mergedLine;
        end else if (wordWrite) begin
            lines[index][wordSel*wordWidth +: wordWidth] <= WData;
        end
    end

    ////////////////////
    // Lookup
    ////////////////////

    assign hit         = valid[index] && (tags[index] == reqTag);
    assign victimDirty = valid[index] && dirty[index];

    // Selected word of the indexed line
    assign RData = lines[index][wordSel*wordWidth +: wordWidth];

    // Victim rebuilt from stored tag plus index
    assign lineWriteAddr = {tags[index], index, {offsetBits{1'b0}}};
    assign lineWriteData = lines[index];

    // Request address, line aligned
    assign lineFillAddr = {Address[wordWidth-1:offsetBits], {offsetBits{1'b0}}};

endmodule

// File: design/storeMerge.sv
`timescale 1ns/10ps

module storeMerge import dataCachePkg::*; (
    input  logic                 Clk,
    input  logic                 arstN,
    // Store capture on a write miss
    input  logic                 captureStore,
    input  logic [wordWidth-1:0] Address,
    input  logic [wordWidth-1:0] WData,
    // Merge select and incoming line
    input  logic                 mergeStore,
    input  logic [lineWidth-1:0] lineFillData,
    output logic [lineWidth-1:0] mergedLine
);

    ////////////////////
    // Store buffer
    ////////////////////

    logic [wordWidth-1:0]   storeWord;
    logic [wordSelBits-1:0] storeOffset;

    // Fill data only valid on the done pulse
    // sampled every cycle, so refill sees the pulse-cycle line
    logic [lineWidth-1:0]   fillLine;

    // Pending store word and its slot in the line
    always_ff @(posedge Clk or negedge arstN) begin
        if (!arstN) begin
            storeWord   <= '0;
            storeOffset <= '0;
        end else if (captureStore) begin
            storeWord   <= WData;
            storeOffset <= Address[wordSelLow +: wordSelBits];
        end
    end

    always_ff @(posedge Clk) begin
        fillLine <= lineFillData;
    end

    // Swap in the buffered word, otherwise pass the line as is
    always_comb begin
        mergedLine = fillLine;
        if (mergeStore) begin
            mergedLine[storeOffset*wordWidth +: wordWidth] = storeWord;
        end
    end

endmodule

// File: design/dataCachePkg.sv
package dataCachePkg;

    ////////////////////
    // Data path widths
    ////////////////////

    // Processor word
    localparam int wordWidth = 32;

    // One cache line, eight words
    localparam int lineWidth = 256;
    localparam int wordsPerLine = lineWidth / wordWidth;

    // Byte offset inside a line
    // Bits 4..2 pick the word, bits 1..0 are ignored
    localparam int offsetBits = 5;
    localparam int wordSelLow = 2;
    localparam int wordSelBits = offsetBits - wordSelLow;

    ////////////////////
    // Controller states
    ////////////////////

    // idle       hit service, miss detection
    // writeBack  dirty victim goes out to memory
    // fill       waiting for the missing line
    // refill     line install, write miss retires here
    typedef enum logic [1:0] {
        idle,
        writeBack,
        fill,
        refill
    } cacheState;

endpackage
